//--- list.f
+incdir+testbench
logic/retire_pkg.sv
logic/retire_latch.sv
logic/retire_regfile.sv
logic/hilo_unit.sv
logic/writeback_top.sv
testbench/tb_writeback.sv

//--- testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// one retire group as issued along with its flush level
typedef struct packed {
    logic                         flush;
    retire_rec_t [lane_count-1:0] lanes;
} group_t;

function automatic logic lane_writes_reg(input retire_rec_t rec, input int r);
    return rec.valid && rec.regwrite && (int'(rec.wa) == r);
endfunction

// next value of general register r once the group retires
function automatic word_t model_reg(input word_t cur, input int r, input group_t g);
    word_t res;
    res = cur;
    if (r == 0) begin
        res = '0;
    end else if (!g.flush) begin
        // lane 0 has priority
        if (lane_writes_reg(g.lanes[0], r)) begin
            res = g.lanes[0].wd;
        end else if (lane_writes_reg(g.lanes[1], r)) begin
            res = g.lanes[1].wd;
        end
    end
    return res;
endfunction

// full 64-bit value a lane offers against the committed pair
function automatic dword_t lane_value(input retire_rec_t rec, input dword_t cur);
    dword_t res;
    if (rec.move_src) begin
        res = {rec.srca, rec.srca};
    end else if (rec.hilo_op == hilo_add) begin
        res = cur + rec.product;
    end else if (rec.hilo_op == hilo_sub) begin
        res = cur - rec.product;
    end else begin
        res = rec.product;
    end
    return res;
endfunction

// next hi:lo with each half from the first lane that writes it
function automatic dword_t model_hilo(input dword_t cur, input group_t g);
    dword_t res;
    dword_t cand;
    logic   hi_taken;
    logic   lo_taken;
    res      = cur;
    hi_taken = 1'b0;
    lo_taken = 1'b0;
    if (!g.flush) begin
        for (int i = 0; i < lane_count; i++) begin
            cand = lane_value(g.lanes[i], cur);
            if (g.lanes[i].valid && g.lanes[i].hiwrite && !hi_taken) begin
                res[63:32] = cand[63:32];
                hi_taken   = 1'b1;
            end
            if (g.lanes[i].valid && g.lanes[i].lowrite && !lo_taken) begin
                res[31:0] = cand[31:0];
                lo_taken  = 1'b1;
            end
        end
    end
    return res;
endfunction

`endif

//--- testbench/tb_writeback.sv
module tb_writeback
    import retire_pkg::*;
();

    `include "tb_model.svh"

    logic                         clk;
    logic                         reset;
    retire_rec_t [lane_count-1:0] i_lane;
    logic                         i_flush;
    reg_addr_t   [read_count-1:0] i_ra;
    word_t       [read_count-1:0] o_rd;
    word_t                        o_hi;
    word_t                        o_lo;

    integer seed = 41557;

    // groups driven but not yet folded into the shadow state
    group_t pending [$];
    word_t  shadow_regs [reg_count] = '{default: '0};
    dword_t shadow_hilo = '0;

    int issued = 0;
    int applied = 0;
    int check_count = 0;
    int error_count = 0;
    int test_count = 0;
    logic [4:0] sweep = '0;

    writeback_top writeback_top_inst (
        .clk     (clk),
        .reset   (reset),
        .i_lane  (i_lane),
        .i_flush (i_flush),
        .i_ra    (i_ra),
        .o_rd    (o_rd),
        .o_hi    (o_hi),
        .o_lo    (o_lo)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error: time %0t, %s, got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // results show two edges after the drive and the last two groups stay pending
    always @(negedge clk) begin : compare_outputs
        group_t g;
        if (!reset) begin
            while (pending.size() > 2) begin
                g = pending.pop_front();
                for (int r = 0; r < reg_count; r++) begin
                    shadow_regs[r] = model_reg(shadow_regs[r], r, g);
                end
                shadow_hilo = model_hilo(shadow_hilo, g);
                applied++;
            end
            check_value("o_hi", o_hi, shadow_hilo[63:32]);
            check_value("o_lo", o_lo, shadow_hilo[31:0]);
            for (int p = 0; p < read_count; p++) begin
                check_value($sformatf("o_rd[%0d] (r%0d)", p, i_ra[p]), o_rd[p],
                            shadow_regs[i_ra[p]]);
            end
        end
    end

    task automatic random_rec(output retire_rec_t rec);
        rec.valid    = 1'b1;
        rec.regwrite = $random(seed);
        rec.wa       = $random(seed);
        rec.wd       = $random(seed);
        rec.hiwrite  = $random(seed);
        rec.lowrite  = $random(seed);
        rec.move_src = $random(seed);
        rec.hilo_op  = hilo_op_t'($unsigned($random(seed)) % 3);
        rec.srca     = $random(seed);
        rec.product  = {$random(seed), $random(seed)};
    endtask

    // kind 1 idle, 2 regs, 3 hi/lo loads, 4 accumulate, 5 flush mix, 6 invalid lanes
    task automatic build_group(input int kind, output group_t g);
        retire_rec_t rec;
        g = '0;
        for (int i = 0; i < lane_count; i++) begin
            random_rec(rec);
            case (kind)
                1: rec = '0;
                2: begin
                    rec.regwrite = 1'b1;
                    rec.hiwrite  = 1'b0;
                    rec.lowrite  = 1'b0;
                end
                3: begin
                    rec.regwrite = 1'b0;
                    rec.hilo_op  = hilo_none;
                end
                4: begin
                    rec.regwrite = 1'b0;
                    rec.move_src = 1'b0;
                end
                6: begin
                    rec.valid    = $random(seed);
                    rec.regwrite = 1'b1;
                    rec.hiwrite  = 1'b1;
                    rec.lowrite  = 1'b1;
                end
                default: ;
            endcase
            g.lanes[i] = rec;
        end
        if (kind == 2) begin
            // same-address conflicts and r0 writes
            if (($unsigned($random(seed)) % 4) == 0) begin
                g.lanes[1].wa = g.lanes[0].wa;
            end
            if (($unsigned($random(seed)) % 8) == 0) begin
                g.lanes[0].wa = '0;
            end
        end
        if (kind == 5) begin
            g.flush = ($unsigned($random(seed)) % 3) == 0;
        end
    endtask

    task automatic drive_group(input group_t g);
        @(posedge clk);
        i_lane  <= g.lanes;
        i_flush <= g.flush;
        i_ra[0] <= sweep;
        i_ra[1] <= sweep + 5'd16;
        sweep = sweep + 5'd1;
        pending.push_back(g);
        issued++;
    endtask

    task automatic run_test(input string name, input int kind, input int cycles);
        group_t g;
        int     checks_before;
        int     errors_before;
        int     target;
        int     waited;
        checks_before = check_count;
        errors_before = error_count;
        for (int c = 0; c < cycles; c++) begin
            build_group(kind, g);
            drive_group(g);
        end
        // idle until every group of this test is visible
        target = issued;
        waited = 0;
        while (applied < target && waited < 10) begin
            build_group(1, g);
            drive_group(g);
            waited++;
        end
        if (applied < target) begin
            error_count++;
            $display("timeout in %s: %0d retire groups never reached the outputs", name,
                     target - applied);
        end else begin
            test_count++;
            $display("test %s done: %0d checks, %0d errors", name,
                     check_count - checks_before, error_count - errors_before);
        end
    endtask

    initial begin
        reset   = 1'b1;
        i_lane  = '0;
        i_flush = 1'b0;
        i_ra    = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        run_test("reset_state", 1, 16);
        run_test("reg_writes", 2, 200);
        run_test("hilo_loads", 3, 100);
        run_test("hilo_accumulate", 4, 200);
        run_test("flush", 5, 150);
        run_test("invalid_lanes", 6, 150);

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- logic/writeback_top.sv
module writeback_top
    import retire_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,

    // retire group from the third memory stage
    input  retire_rec_t [lane_count-1:0] i_lane,
    input  logic                         i_flush,

    // register file read side
    input  reg_addr_t   [read_count-1:0] i_ra,
    output word_t       [read_count-1:0] o_rd,

    // committed hi/lo
    output word_t                        o_hi,
    output word_t                        o_lo
);

    // records in the writeback stage, already qualified
    retire_rec_t [lane_count-1:0] lane_w;

    // m3 to writeback register
    retire_latch retire_latch_inst (
        .clk     (clk),
        .reset   (reset),
        .i_lane  (i_lane),
        .i_flush (i_flush),
        .o_lane  (lane_w)
    );

    // general registers
    retire_regfile retire_regfile_inst (
        .clk    (clk),
        .reset  (reset),
        .i_lane (lane_w),
        .i_ra   (i_ra),
        .o_rd   (o_rd)
    );

    // hi/lo with merge and accumulate
    hilo_unit hilo_unit_inst (
        .clk    (clk),
        .reset  (reset),
        .i_lane (lane_w),
        .o_hi   (o_hi),
        .o_lo   (o_lo)
    );

endmodule

//--- logic/hilo_unit.sv
module hilo_unit
    import retire_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  retire_rec_t [lane_count-1:0] i_lane,
    output word_t                        o_hi,
    output word_t                        o_lo
);

    // committed hi and lo
    word_t hi_q;
    word_t lo_q;

    // committed pair as one 64-bit value
    dword_t hilo_cur;

    // what each lane would write to both halves
    dword_t [lane_count-1:0] lane_cand;

    // merged next values and load strobes
    word_t hi_next;
    word_t lo_next;
    logic  hi_load;
    logic  lo_load;

    assign hilo_cur = {hi_q, lo_q};

    // candidate for one lane against the committed pair
    function automatic dword_t lane_result(input retire_rec_t rec, input dword_t cur);
        dword_t res;
        if (rec.move_src) begin
            // mthi and mtlo both take rs
            res = {rec.srca, rec.srca};
        end else begin
            case (rec.hilo_op)
                hilo_add: res = cur + rec.product;
                hilo_sub: res = cur - rec.product;
                default:  res = rec.product;
            endcase
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < lane_count; i++) begin
            lane_cand[i] = lane_result(i_lane[i], hilo_cur);
        end
    end

    // halves merged on their own with lane 0 checked last
    always_comb begin
        hi_next = hi_q;
        lo_next = lo_q;
        hi_load = 1'b0;
        lo_load = 1'b0;
        for (int i = lane_count - 1; i >= 0; i--) begin
            if (i_lane[i].hiwrite) begin
                hi_next = lane_cand[i][63:32];
                hi_load = 1'b1;
            end
            if (i_lane[i].lowrite) begin
                lo_next = lane_cand[i][31:0];
                lo_load = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (hi_load) begin
                hi_q <= hi_next;
            end
            if (lo_load) begin
                lo_q <= lo_next;
            end
        end
    end

    // straight from the registers
    assign o_hi = hi_q;
    assign o_lo = lo_q;

endmodule

//--- logic/retire_regfile.sv
module retire_regfile
    import retire_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  retire_rec_t [lane_count-1:0] i_lane,
    input  reg_addr_t   [read_count-1:0] i_ra,
    output word_t       [read_count-1:0] o_rd
);

    // register storage
    word_t regs [reg_count];

    // per-lane write strobe that skips r0
    logic [lane_count-1:0] lane_we;

    always_comb begin
        for (int i = 0; i < lane_count; i++) begin
            lane_we[i] = i_lane[i].regwrite && (i_lane[i].wa != '0);
        end
    end

    // higher lanes first so lane 0 lands last and wins
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < reg_count; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = lane_count - 1; i >= 0; i--) begin
                if (lane_we[i]) begin
                    regs[i_lane[i].wa] <= i_lane[i].wd;
                end
            end
        end
    end

    // asynchronous read of the stored contents
    always_comb begin
        for (int p = 0; p < read_count; p++) begin
            o_rd[p] = regs[i_ra[p]];
        end
    end

endmodule

//--- logic/retire_latch.sv
module retire_latch
    import retire_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  retire_rec_t [lane_count-1:0] i_lane,
    input  logic                         i_flush,
    output retire_rec_t [lane_count-1:0] o_lane
);

    // registered records from the last memory stage
    retire_rec_t [lane_count-1:0] lane_q;

    // payload follows the input every cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < lane_count; i++) begin
            lane_q[i] <= i_lane[i];
        end
        // a flush or reset kills the whole group
        if (reset || i_flush) begin
            for (int i = 0; i < lane_count; i++) begin
                lane_q[i].valid <= 1'b0;
            end
        end
    end

    // dead slots must not write anything downstream
    always_comb begin
        o_lane = lane_q;
        for (int i = 0; i < lane_count; i++) begin
            if (!lane_q[i].valid) begin
                o_lane[i].regwrite = 1'b0;
                o_lane[i].hiwrite  = 1'b0;
                o_lane[i].lowrite  = 1'b0;
            end
        end
    end

endmodule

//--- logic/retire_pkg.sv
package retire_pkg;

    // machine word and the joined hi:lo pair
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;

    // general register number
    typedef logic [4:0] reg_addr_t;

    // two instructions leave the pipe per cycle
    localparam int lane_count = 2;

    // mips general registers with r0 hardwired to zero
    localparam int reg_count = 32;

    // read ports on the register file
    localparam int read_count = 2;

    // how a lane updates hi/lo
    typedef enum logic [1:0] {
        // plain load of the product or the move source
        hilo_none = 2'd0,
        // madd adds the product to the accumulator
        hilo_add  = 2'd1,
        // msub subtracts the product from the accumulator
        hilo_sub  = 2'd2
    } hilo_op_t;

    // one instruction as it reaches writeback
    typedef struct packed {
        // slot holds a live instruction
        logic      valid;

        // general register write
        logic      regwrite;
        reg_addr_t wa;
        word_t     wd;

        // one hi/lo write enable per half
        logic      hiwrite;
        logic      lowrite;

        // mthi/mtlo take srca and not the product
        logic      move_src;
        hilo_op_t  hilo_op;

        // rs operand for the moves
        word_t     srca;

        // full 64-bit multiplier output
        dword_t    product;
    } retire_rec_t;

endpackage
